// ==== common/ac_pkg.sv ====
package ac_pkg;

	// Pixel and beat geometry
	localparam int PIX_W        = 24;
	localparam int PIX_PER_BEAT = 4;
	localparam int BEAT_W       = PIX_W * PIX_PER_BEAT;

	// Destination image size
	localparam int DST_ROW_PIX   = 16;
	localparam int BEATS_PER_ROW = DST_ROW_PIX / PIX_PER_BEAT;
	localparam int DST_ROWS      = 4;

	// Output buffer
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	// Config register file write port
	localparam int CRF_DATA_W = 32;

	// One beat holds PIX_PER_BEAT RGB pixels, pixel 0 in the low bits
	typedef logic [BEAT_W-1:0] beat_t;

	typedef logic [CRF_DATA_W-1:0] crf_data_t;

	// Beat position inside a destination row
	typedef logic [$clog2(BEATS_PER_ROW)-1:0] row_beat_t;

	// Must reach DST_ROWS without wrapping
	typedef logic [$clog2(DST_ROWS+1)-1:0] line_cnt_t;

	// Top bit is the wrap flag used to tell full from empty
	typedef logic [FIFO_AW:0] fifo_ptr_t;

endpackage

// ==== hdl/run_control.sv ====
`timescale 1ns/1ps

module run_control (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              upstart,
	input  logic              upend,
	input  logic              final_tvalid,
	input  logic              final_tready,
	input  logic              final_tlast,
	output logic              processing,
	output logic              time_window,
	output logic              frame_done,
	output logic              upsp_reset,
	output logic              crf_wrt,
	output ac_pkg::crf_data_t crf_wdata
);

	import ac_pkg::*;

	line_cnt_t line_cnt;
	logic      line_done;
	logic      last_line;
	logic      start_cond;
	logic      stop_cond;
	logic      wr_clear_start;
	logic      wr_set_end;

	// One output line leaves the final stream on every tlast handshake
	assign line_done = final_tvalid & final_tready & final_tlast;
	assign last_line = (line_cnt == line_cnt_t'(DST_ROWS - 1));
	assign frame_done = line_done & last_line;

	// Host has requested a run and the previous one is fully closed
	assign start_cond = upstart & ~upend & ~processing;
	// Host has acknowledged the end of the run
	assign stop_cond = ~upstart & upend & processing;

	// Status write rules, first match wins
	assign wr_clear_start = processing & frame_done & upstart;
	assign wr_set_end     = processing & ~upstart & ~upend;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_cnt <= '0;
		end else if (frame_done) begin
			line_cnt <= '0;
		end else if (line_done) begin
			line_cnt <= line_cnt + line_cnt_t'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processing <= 1'b0;
		end else if (start_cond) begin
			processing <= 1'b1;
		end else if (stop_cond) begin
			processing <= 1'b0;
		end
	end

	// Up-sampler may only write between start and the last output line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_window <= 1'b0;
		end else if (start_cond) begin
			time_window <= 1'b1;
		end else if (wr_clear_start) begin
			time_window <= 1'b0;
		end
	end

	// Up-sampler restarts one cycle after the frame completes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			upsp_reset <= 1'b0;
		end else begin
			upsp_reset <= frame_done;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crf_wrt <= 1'b0;
		end else begin
			crf_wrt <= wr_clear_start | wr_set_end;
		end
	end

	// bit 0 is UPSTART, bit 1 is UPEND
	always_ff @(posedge clk) begin
		if (wr_clear_start) begin
			crf_wdata <= {{(CRF_DATA_W-2){1'b0}}, upend, 1'b0};
		end else if (wr_set_end) begin
			crf_wdata <= {{(CRF_DATA_W-2){1'b0}}, 1'b1, 1'b0};
		end
	end

	// Final stream can only complete a frame while a run and its window are open
	assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> processing && time_window);

endmodule

// ==== out_path/out_fifo.sv ====
`timescale 1ns/1ps

module out_fifo (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          flush,
	input  logic          wr_en,
	input  logic          pop,
	input  ac_pkg::beat_t wdata,
	output logic          full,
	output logic          empty,
	output ac_pkg::beat_t rdata
);

	import ac_pkg::*;

	beat_t     mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;

	// Same slot with different wrap bits means the buffer is full
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
		(wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + fifo_ptr_t'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + fifo_ptr_t'(1);
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[FIFO_AW-1:0]] <= wdata;
		end
	end

	// Popped beat shows up on the next cycle and holds until the next pop
	always_ff @(posedge clk) begin
		if (pop) begin
			rdata <= mem[rd_ptr[FIFO_AW-1:0]];
		end
	end

	// Writer must respect wready
	assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full);

	// Reader must check empty before popping
	assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

// ==== out_path/out_stream_master.sv ====
`timescale 1ns/1ps

module out_stream_master (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          time_window,
	input  logic          frame_done,
	input  logic          fifo_empty,
	input  logic          m_axis_tready,
	input  ac_pkg::beat_t fifo_rdata,
	output logic          fifo_pop,
	output logic          m_axis_tvalid,
	output logic          m_axis_tlast,
	output ac_pkg::beat_t m_axis_tdata
);

	import ac_pkg::*;

	row_beat_t row_beat;
	logic      last_of_row;
	logic      out_free;

	// Output register can take a new beat this cycle
	assign out_free = ~m_axis_tvalid | m_axis_tready;

	// Only drain the buffer while the run window is open
	assign fifo_pop = ~fifo_empty & time_window & out_free;

	assign last_of_row = (row_beat == row_beat_t'(BEATS_PER_ROW - 1));

	// Count popped beats within the current destination row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_beat <= '0;
		end else if (frame_done) begin
			row_beat <= '0;
		end else if (fifo_pop) begin
			if (last_of_row) begin
				row_beat <= '0;
			end else begin
				row_beat <= row_beat + row_beat_t'(1);
			end
		end
	end

	// valid/last move together with the FIFO read register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast  <= 1'b0;
		end else if (out_free) begin
			m_axis_tvalid <= fifo_pop;
			m_axis_tlast  <= fifo_pop & last_of_row;
		end
	end

	// DDR expects the pixels of a beat in reverse order
	always_comb begin
		for (int i = 0; i < PIX_PER_BEAT; i++) begin
			m_axis_tdata[i*PIX_W +: PIX_W] = fifo_rdata[(PIX_PER_BEAT-1-i)*PIX_W +: PIX_W];
		end
	end

	// Beat held under back-pressure, tdata comes straight from the FIFO read port
	assert property (@(posedge clk) disable iff (!rst_n)
		m_axis_tvalid && !m_axis_tready |=>
			m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

endmodule

// ==== hdl/access_control.sv ====
`timescale 1ns/1ps

module access_control (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              upstart,
	input  logic              upend,
	input  logic              upsp_wvalid,
	input  logic              m_axis_tready,
	input  logic              final_tvalid,
	input  logic              final_tready,
	input  logic              final_tlast,
	input  ac_pkg::beat_t     upsp_wdata,
	output logic              processing,
	output logic              crf_wrt,
	output logic              upsp_wready,
	output logic              upsp_reset,
	output logic              m_axis_tvalid,
	output logic              m_axis_tlast,
	output ac_pkg::crf_data_t crf_wdata,
	output ac_pkg::beat_t     m_axis_tdata
);

	import ac_pkg::*;

	logic  time_window;
	logic  frame_done;
	logic  fifo_wr_en;
	logic  fifo_pop;
	logic  fifo_full;
	logic  fifo_empty;
	beat_t fifo_rdata;

	assign upsp_wready = ~fifo_full;

	// Beats offered outside the window are dropped
	assign fifo_wr_en = upsp_wvalid & upsp_wready & time_window;

	run_control u_run_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.upstart      (upstart),
		.upend        (upend),
		.final_tvalid (final_tvalid),
		.final_tready (final_tready),
		.final_tlast  (final_tlast),
		.processing   (processing),
		.time_window  (time_window),
		.frame_done   (frame_done),
		.upsp_reset   (upsp_reset),
		.crf_wrt      (crf_wrt),
		.crf_wdata    (crf_wdata)
	);

	// Leftover beats are discarded at the end of a frame
	out_fifo u_out_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (frame_done),
		.wr_en (fifo_wr_en),
		.pop   (fifo_pop),
		.wdata (upsp_wdata),
		.full  (fifo_full),
		.empty (fifo_empty),
		.rdata (fifo_rdata)
	);

	out_stream_master u_out_stream_master (
		.clk           (clk),
		.rst_n         (rst_n),
		.time_window   (time_window),
		.frame_done    (frame_done),
		.fifo_empty    (fifo_empty),
		.m_axis_tready (m_axis_tready),
		.fifo_rdata    (fifo_rdata),
		.fifo_pop      (fifo_pop),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tdata  (m_axis_tdata)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 10 ns period
	localparam int HALF_PERIOD_NS = 5;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD_NS clk = ~clk;
		end
	end

endmodule

// ==== tests/tb_access_control.sv ====
`timescale 1ns/1ps

module tb_access_control;

	import ac_pkg::*;

	localparam int FRAME_BEATS     = BEATS_PER_ROW * DST_ROWS;
	localparam int JUNK_BEATS      = FIFO_DEPTH + 2;
	localparam int TOTAL_BEATS     = 2 * FRAME_BEATS + JUNK_BEATS;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 400;
	localparam int EXP_DEPTH       = 2 * FRAME_BEATS;
	localparam int CRF_LOG_LEN     = 16;
	localparam int WAIT_LIMIT      = 100;

	logic      clk;
	logic      rst_n;
	logic      upstart      = 1'b0;
	logic      upend        = 1'b0;
	logic      upsp_wvalid;
	logic      m_axis_tready;
	logic      final_tvalid = 1'b0;
	logic      final_tready = 1'b0;
	logic      final_tlast  = 1'b0;
	beat_t     upsp_wdata;
	logic      processing;
	logic      crf_wrt;
	logic      upsp_wready;
	logic      upsp_reset;
	logic      m_axis_tvalid;
	logic      m_axis_tlast;
	crf_data_t crf_wdata;
	beat_t     m_axis_tdata;

	// Host side of the register file
	logic       host_wr_en;
	logic [1:0] host_wr_val;
	crf_data_t  crf_log [CRF_LOG_LEN];
	int         crf_cnt = 0;

	// Scoreboard, filled in write order with the expected output beats
	beat_t exp_beats [EXP_DEPTH];
	int    wr_idx;

	// Output monitor state
	int    out_count   = 0;
	int    reset_cnt   = 0;
	int    stall_cnt   = 0;
	int    mon_errors  = 0;
	int    line_model  = 0;
	logic  reset_due   = 1'b0;
	logic  held_valid  = 1'b0;
	logic  held_last   = 1'b0;
	beat_t held_data   = '0;

	integer seed;
	int     main_errors;
	int     test_base;
	int     tests_run;
	int     tests_passed;
	int     crf_base;
	int     rst_base;
	int     stall_base;

	tb_clock u_tb_clock (
		.clk (clk)
	);

	access_control u_access_control (
		.clk           (clk),
		.rst_n         (rst_n),
		.upstart       (upstart),
		.upend         (upend),
		.upsp_wvalid   (upsp_wvalid),
		.m_axis_tready (m_axis_tready),
		.final_tvalid  (final_tvalid),
		.final_tready  (final_tready),
		.final_tlast   (final_tlast),
		.upsp_wdata    (upsp_wdata),
		.processing    (processing),
		.crf_wrt       (crf_wrt),
		.upsp_wready   (upsp_wready),
		.upsp_reset    (upsp_reset),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.crf_wdata     (crf_wdata),
		.m_axis_tdata  (m_axis_tdata)
	);

	task automatic report_error(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic next_beat(output beat_t b);
		b = {$random(seed), $random(seed), $random(seed)};
	endtask

	task automatic roll_pct(output int r);
		r = $unsigned($random(seed)) % 100;
	endtask

	// Output pixel slot i holds input slot PIX_PER_BEAT-1-i
	function automatic beat_t reverse_pixels(input beat_t b);
		beat_t r;
		r = '0;
		for (int i = 0; i < PIX_PER_BEAT; i++) begin
			r = (r << PIX_W) | beat_t'(b[i*PIX_W +: PIX_W]);
		end
		return r;
	endfunction

	task automatic write_host(input logic [1:0] val);
		@(posedge clk);
		host_wr_val <= val;
		host_wr_en  <= 1'b1;
		@(posedge clk);
		host_wr_en  <= 1'b0;
	endtask

	task automatic wait_for_processing(input logic level);
		int n;
		n = 0;
		while (processing !== level && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (processing !== level) begin
			$display("Timeout: processing did not go to %b within %0d cycles", level, WAIT_LIMIT);
			main_errors++;
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = main_errors + mon_errors - test_base;
		tests_run++;
		if (errs == 0) begin
			tests_passed++;
			$display("Test %0d (%s): pass", tests_run, name);
		end else begin
			$display("Test %0d (%s): fail with %0d errors", tests_run, name, errs);
		end
		test_base = main_errors + mon_errors;
	endtask

	// Feeds one frame of random beats and waits until all of them have left
	task automatic run_frame(input int stall_pct, input int gap_pct);
		int    sent;
		int    target;
		int    roll;
		beat_t beat;
		sent   = 0;
		target = out_count + FRAME_BEATS;
		while (sent < FRAME_BEATS || out_count < target) begin
			@(posedge clk);
			if (upsp_wvalid && upsp_wready) begin
				if (wr_idx < EXP_DEPTH) begin
					exp_beats[wr_idx] = reverse_pixels(upsp_wdata);
				end
				wr_idx++;
				sent++;
			end
			if (sent >= FRAME_BEATS) begin
				upsp_wvalid <= 1'b0;
			end else if (!upsp_wvalid || upsp_wready) begin
				roll_pct(roll);
				if (roll < gap_pct) begin
					upsp_wvalid <= 1'b0;
				end else begin
					next_beat(beat);
					upsp_wvalid <= 1'b1;
					upsp_wdata  <= beat;
				end
			end
			roll_pct(roll);
			m_axis_tready <= (roll >= stall_pct);
		end
		m_axis_tready <= 1'b1;
	endtask

	// Expected: one clear of UPSTART, then UPEND writes until processing drops
	task automatic check_completion(input int crf_from, input int rst_from);
		int n;
		int i;
		wait_for_processing(1'b0);
		repeat (4) @(posedge clk);
		n = crf_cnt - crf_from;
		if (n < 2) begin
			report_error($sformatf("expected clear and UPEND writes, saw %0d writes", n));
			main_errors++;
		end else begin
			if (crf_log[crf_from] !== crf_data_t'(0)) begin
				report_error($sformatf("first write %h, expected 0", crf_log[crf_from]));
				main_errors++;
			end
			for (i = crf_from + 1; i < crf_cnt && i < CRF_LOG_LEN; i++) begin
				if (crf_log[i] !== crf_data_t'(2)) begin
					report_error($sformatf("write %0d is %h, expected 2", i - crf_from, crf_log[i]));
					main_errors++;
				end
			end
		end
		if (upstart !== 1'b0 || upend !== 1'b1) begin
			report_error($sformatf("register holds UPSTART %b UPEND %b", upstart, upend));
			main_errors++;
		end
		if (reset_cnt - rst_from != 1) begin
			report_error($sformatf("upsp_reset high %0d cycles, expected 1", reset_cnt - rst_from));
			main_errors++;
		end
		if (out_count != wr_idx) begin
			report_error($sformatf("%0d beats accepted, %0d sent out", wr_idx, out_count));
			main_errors++;
		end
	endtask

	// More beats than the buffer holds, so any stored beat would drop wready
	task automatic offer_outside_window();
		int    base;
		int    i;
		logic  saw_valid;
		logic  saw_full;
		beat_t beat;
		base      = out_count;
		saw_valid = 1'b0;
		saw_full  = 1'b0;
		if (processing !== 1'b0) begin
			report_error("processing still high before the out-of-window beats");
			main_errors++;
		end
		for (i = 0; i < JUNK_BEATS + 12; i++) begin
			@(posedge clk);
			if (m_axis_tvalid) begin
				saw_valid = 1'b1;
			end
			if (!upsp_wready) begin
				saw_full = 1'b1;
			end
			if (i < JUNK_BEATS) begin
				next_beat(beat);
				upsp_wvalid <= 1'b1;
				upsp_wdata  <= beat;
			end else begin
				upsp_wvalid <= 1'b0;
			end
		end
		if (saw_valid || out_count != base) begin
			report_error($sformatf("%0d beats left outside the window", out_count - base));
			main_errors++;
		end
		if (saw_full) begin
			report_error("upsp_wready fell, beats were stored outside the window");
			main_errors++;
		end
	endtask

	// Register file, status writes from the DUT take priority over the host
	always @(posedge clk) begin
		if (!rst_n) begin
			upstart <= 1'b0;
			upend   <= 1'b0;
		end else if (crf_wrt) begin
			upstart <= crf_wdata[0];
			upend   <= crf_wdata[1];
			if (crf_cnt < CRF_LOG_LEN) begin
				crf_log[crf_cnt] <= crf_wdata;
			end
			crf_cnt <= crf_cnt + 1;
		end else if (host_wr_en) begin
			upstart <= host_wr_val[0];
			upend   <= host_wr_val[1];
		end
	end

	// Output checker and downstream model echoing each beat onto the final stream
	always @(posedge clk) begin
		int   edge_errs;
		logic exp_last;
		edge_errs = 0;
		if (!rst_n) begin
			final_tvalid <= 1'b0;
			final_tready <= 1'b0;
			final_tlast  <= 1'b0;
			held_valid   <= 1'b0;
			reset_due    <= 1'b0;
			line_model   <= 0;
		end else begin
			if (held_valid) begin
				if (m_axis_tvalid !== 1'b1 || m_axis_tdata !== held_data ||
					m_axis_tlast !== held_last) begin
					report_error("output beat changed while tready was low");
					edge_errs++;
				end
			end
			held_valid <= m_axis_tvalid && !m_axis_tready;
			held_data  <= m_axis_tdata;
			held_last  <= m_axis_tlast;
			if (m_axis_tvalid && !m_axis_tready) begin
				stall_cnt <= stall_cnt + 1;
			end
			if (m_axis_tvalid && m_axis_tready) begin
				exp_last = ((out_count % BEATS_PER_ROW) == BEATS_PER_ROW - 1);
				if (out_count >= wr_idx || out_count >= EXP_DEPTH) begin
					report_error($sformatf("output beat %0d has no matching write", out_count));
					edge_errs++;
				end else if (m_axis_tdata !== exp_beats[out_count]) begin
					report_error($sformatf("beat %0d tdata %h, expected %h",
						out_count, m_axis_tdata, exp_beats[out_count]));
					edge_errs++;
				end
				if (m_axis_tlast !== exp_last) begin
					report_error($sformatf("beat %0d tlast %b, expected %b",
						out_count, m_axis_tlast, exp_last));
					edge_errs++;
				end
				out_count    <= out_count + 1;
				final_tvalid <= 1'b1;
				final_tready <= 1'b1;
				final_tlast  <= m_axis_tlast;
			end else begin
				final_tvalid <= 1'b0;
				final_tready <= 1'b0;
				final_tlast  <= 1'b0;
			end
			// upsp_reset follows the last output line by one cycle
			if (upsp_reset !== reset_due) begin
				report_error($sformatf("upsp_reset %b, expected %b", upsp_reset, reset_due));
				edge_errs++;
			end
			if (upsp_reset) begin
				reset_cnt <= reset_cnt + 1;
			end
			reset_due <= 1'b0;
			if (final_tvalid && final_tready && final_tlast) begin
				if (line_model == DST_ROWS - 1) begin
					line_model <= 0;
					reset_due  <= 1'b1;
				end else begin
					line_model <= line_model + 1;
				end
			end
		end
		mon_errors <= mon_errors + edge_errs;
	end

	initial begin
		seed          = 18113;
		main_errors   = 0;
		test_base     = 0;
		tests_run     = 0;
		tests_passed  = 0;
		wr_idx        = 0;
		rst_n         = 1'b0;
		host_wr_en    = 1'b0;
		host_wr_val   = 2'b00;
		upsp_wvalid   = 1'b0;
		upsp_wdata    = '0;
		m_axis_tready = 1'b0;
		repeat (16) @(posedge clk);
		rst_n         <= 1'b1;
		m_axis_tready <= 1'b1;
		repeat (4) @(posedge clk);

		crf_base = crf_cnt;
		rst_base = reset_cnt;
		write_host(2'b01);
		wait_for_processing(1'b1);
		repeat (8) @(posedge clk);
		if (crf_cnt != crf_base) begin
			report_error("register write while UPSTART was set");
			main_errors++;
		end
		end_test("start");

		run_frame(0, 0);
		if (crf_cnt != crf_base) begin
			report_error("register write before the frame completed");
			main_errors++;
		end
		end_test("data path");

		check_completion(crf_base, rst_base);
		end_test("completion");

		offer_outside_window();
		end_test("outside window");

		// Second run under random back-pressure and write gaps
		crf_base   = crf_cnt;
		rst_base   = reset_cnt;
		stall_base = stall_cnt;
		write_host(2'b01);
		wait_for_processing(1'b1);
		run_frame(40, 30);
		if (stall_cnt == stall_base) begin
			$display("Error: no back-pressure cycle occurred in the second frame");
			main_errors++;
		end
		if (crf_cnt != crf_base) begin
			report_error("register write before the second frame completed");
			main_errors++;
		end
		end_test("back-pressure");

		check_completion(crf_base, rst_base);
		end_test("second frame completion");

		$display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_passed, tests_run - tests_passed, main_errors + mon_errors);
		if (main_errors + mon_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== project.f ====
common/ac_pkg.sv
hdl/run_control.sv
out_path/out_fifo.sv
out_path/out_stream_master.sv
hdl/access_control.sv
tests/tb_clock.sv
tests/tb_access_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the access controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_access_control \
	-f project.f \
	--Mdir obj_dir -o tb_access_control
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_access_control > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF '*** PASSED ***' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
